// File: rtl/raster_pkg.sv
// raster_pkg: coordinate, color and line command types, frame store and queue sizes
package raster_pkg;

    // coordinate system
    localparam int COORD_W = 8;           // signed, lines may leave the screen

    // frame store geometry
    localparam int FB_W    = 32;          // visible width in pixels
    localparam int FB_H    = 32;          // visible height in pixels
    localparam int FB_AW   = 10;          // address is y * FB_W + x

    // pixel color
    localparam int COLOR_W = 4;

    // command queue, also the host's starting credit count
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_AW    = $clog2(QUEUE_DEPTH);

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic [COLOR_W-1:0]        color_t;

    // one line request, 36 bits packed
    typedef struct packed {
        coord_t sx;                       // start point
        coord_t sy;
        coord_t ex;                       // end point
        coord_t ey;
        color_t color;
    } line_cmd_t;

endpackage

// File: rtl/pix_if.sv
// pix_if: pixel stream from the line drawer to the frame store, source and sink modports
`timescale 1ns/1ps

interface pix_if;
    import raster_pkg::*;

    logic   valid;                        // pixel offered
    logic   ready;                        // store can take it
    coord_t x;
    coord_t y;
    color_t color;

    // drawer side
    modport source (
        output valid, x, y, color,
        input  ready
    );

    // frame store side
    modport sink (
        input  valid, x, y, color,
        output ready
    );

endinterface

// File: rtl/cmd_queue.sv
// cmd_queue: circular command FIFO with one credit returned per pop
`timescale 1ns/1ps

module cmd_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  raster_pkg::line_cmd_t push_cmd,
    input  logic                  pop,
    output logic                  valid,
    output raster_pkg::line_cmd_t head,
    output logic                  credit
);
    import raster_pkg::*;

    line_cmd_t           mem [QUEUE_DEPTH];   // payload storage, no reset
    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_AW:0]   count;               // occupancy 0..QUEUE_DEPTH

    // payload write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;      // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    assign valid = (count != '0);
    assign head  = mem[rd_ptr];

    // freed slot goes straight back to the host
    assign credit = pop;

    // host pushed without holding a credit
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst)
        push |-> (count != (QUEUE_AW + 1)'(QUEUE_DEPTH))
    ) else $error("cmd_queue: push while full, credit violation");

    // drawer popped an empty queue
    a_no_underflow : assert property (
        @(posedge clk) disable iff (rst)
        pop |-> valid
    ) else $error("cmd_queue: pop while empty");

endmodule

// File: rtl/line_drawer.sv
// line_drawer: Bresenham line stepping with setup FSM and pixel back-pressure
`timescale 1ns/1ps

module line_drawer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  raster_pkg::line_cmd_t cmd,
    output logic                  cmd_pop,
    output logic                  busy,
    output logic                  line_done,
    pix_if.source                 pix
);
    import raster_pkg::*;

    localparam int DW    = COORD_W + 1;   // delta width
    localparam int ERR_W = COORD_W + 2;   // headroom for err + dy

    typedef enum logic [2:0] {
        IDLE,
        SETUP_0,
        SETUP_1,
        DRAW,
        DONE
    } state_t;

    state_t    state;
    line_cmd_t cmd_q;                     // command latched at pop

    logic signed [DW-1:0]    dx;          // abs x span
    logic signed [DW-1:0]    dy;          // negated abs y span
    logic signed [ERR_W-1:0] err;
    logic signed [ERR_W:0]   err_2;       // 2 * err
    logic signed [ERR_W-1:0] err_next;
    logic signed [DW-1:0]    dx_c;
    logic signed [DW-1:0]    dy_c;

    coord_t x, y;                         // current position
    coord_t x_end, y_end;                 // end point after swap
    logic   right;                        // x walks upward
    logic   swap;
    logic   mov_x, mov_y;
    logic   at_end;

    // endpoint order so that y never decreases
    assign swap = (cmd_q.sy > cmd_q.ey);

    // deltas from the swapped points held in x/y and x_end/y_end
    assign dx_c = right ? (x_end - x) : (x - x_end);
    assign dy_c = y - y_end;

    // error rule
    always_comb begin
        err_2    = {err, 1'b0};
        mov_x    = (err_2 >= dy);
        mov_y    = (err_2 <= dx);
        err_next = err;
        if (mov_x) begin
            err_next = err_next + dy;
        end
        if (mov_y) begin
            err_next = err_next + dx;
        end
    end

    assign at_end = (x == x_end) && (y == y_end);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        cmd_q <= cmd;         // head moves on this pop
                        state <= SETUP_0;
                    end
                end
                SETUP_0: begin
                    x     <= swap ? cmd_q.ex : cmd_q.sx;
                    y     <= swap ? cmd_q.ey : cmd_q.sy;
                    x_end <= swap ? cmd_q.sx : cmd_q.ex;
                    y_end <= swap ? cmd_q.sy : cmd_q.ey;
                    right <= swap ? (cmd_q.ex < cmd_q.sx) : (cmd_q.sx < cmd_q.ex);
                    state <= SETUP_1;
                end
                SETUP_1: begin
                    dx    <= dx_c;
                    dy    <= dy_c;
                    err   <= dx_c + dy_c;
                    state <= DRAW;
                end
                DRAW: begin
                    if (pix.ready) begin      // stalled otherwise
                        if (at_end) begin
                            state <= DONE;
                        end else begin
                            if (mov_x) begin
                                x <= right ? x + coord_t'(1) : x - coord_t'(1);
                            end
                            if (mov_y) begin
                                y <= y + coord_t'(1);     // always downward
                            end
                            err <= err_next;
                        end
                    end
                end
                default: begin                // DONE
                    state <= IDLE;
                end
            endcase
        end
    end

    assign cmd_pop   = (state == IDLE) && cmd_valid;
    assign busy      = (state != IDLE);
    assign line_done = (state == DONE);

    assign pix.valid = (state == DRAW);
    assign pix.x     = x;
    assign pix.y     = y;
    assign pix.color = cmd_q.color;

    // offered pixel must not move until the store takes it
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (rst)
        (pix.valid && !pix.ready) |=>
            (pix.valid && $stable(pix.x) && $stable(pix.y) && $stable(pix.color))
    ) else $error("line_drawer: pixel changed while stalled");

endmodule

// File: rtl/frame_store.sv
// frame_store: pixel clipping, 32x32 color memory, host read port with priority
`timescale 1ns/1ps

module frame_store (
    input  logic               clk,
    input  logic               rst,
    pix_if.sink                pix,
    input  logic               rd_en,
    input  raster_pkg::coord_t rd_x,
    input  raster_pkg::coord_t rd_y,
    output raster_pkg::color_t rd_data,
    output logic               pix_clipped
);
    import raster_pkg::*;

    color_t mem [FB_W * FB_H];            // contents undefined until drawn

    logic             xfer;
    logic             visible;
    logic [FB_AW-1:0] wr_addr;
    logic [FB_AW-1:0] rd_addr;

    // host read owns the port this cycle
    assign pix.ready = !rd_en;
    assign xfer      = pix.valid && pix.ready;

    // inside 0 <= x < FB_W and 0 <= y < FB_H
    assign visible = (pix.x >= 0) && (pix.x < FB_W)
                  && (pix.y >= 0) && (pix.y < FB_H);

    // only meaningful for on-screen points
    assign wr_addr = FB_AW'(pix.y * FB_W + pix.x);
    assign rd_addr = FB_AW'(rd_y * FB_W + rd_x);

    // pixel write
    always_ff @(posedge clk) begin
        if (xfer && visible) begin
            mem[wr_addr] <= pix.color;
        end
    end

    // read data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // accepted but dropped
    assign pix_clipped = xfer && !visible;

endmodule

// File: rtl/line_raster_top.sv
// line_raster_top: command queue, line drawer and frame store with host-side plain ports
`timescale 1ns/1ps

module line_raster_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cmd_valid,
    input  raster_pkg::coord_t cmd_sx,
    input  raster_pkg::coord_t cmd_sy,
    input  raster_pkg::coord_t cmd_ex,
    input  raster_pkg::coord_t cmd_ey,
    input  raster_pkg::color_t cmd_color,
    output logic               credit,
    input  logic               rd_en,
    input  raster_pkg::coord_t rd_x,
    input  raster_pkg::coord_t rd_y,
    output raster_pkg::color_t rd_data,
    output logic               busy,
    output logic               line_done,
    output logic               pix_clipped
);
    import raster_pkg::*;

    line_cmd_t host_cmd;                  // packed host fields
    line_cmd_t q_cmd;                     // queue head
    logic      q_valid;
    logic      q_pop;

    assign host_cmd = '{sx: cmd_sx, sy: cmd_sy, ex: cmd_ex, ey: cmd_ey, color: cmd_color};

    pix_if pix_bus ();

    cmd_queue queue_i (
        .clk      (clk),
        .rst      (rst),
        .push     (cmd_valid),            // no ready, credits guard it
        .push_cmd (host_cmd),
        .pop      (q_pop),
        .valid    (q_valid),
        .head     (q_cmd),
        .credit   (credit)
    );

    line_drawer drawer_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (q_valid),
        .cmd       (q_cmd),
        .cmd_pop   (q_pop),
        .busy      (busy),
        .line_done (line_done),
        .pix       (pix_bus.source)
    );

    frame_store store_i (
        .clk         (clk),
        .rst         (rst),
        .pix         (pix_bus.sink),
        .rd_en       (rd_en),
        .rd_x        (rd_x),
        .rd_y        (rd_y),
        .rd_data     (rd_data),
        .pix_clipped (pix_clipped)
    );

endmodule

// File: bench/line_tb_table.svh
// line command table: endpoints, color, expected pixel and clip counts, queued flag
`ifndef LINE_TB_TABLE_SVH
`define LINE_TB_TABLE_SVH

// columns: sx, sy, ex, ey, color, expected pixels, expected clips, queued
typedef struct packed {
    int sx;
    int sy;
    int ex;
    int ey;
    int color;
    int exp_pix;
    int exp_clip;
    bit queued;                           // pushed back to back with the other queued rows
} line_entry_t;

localparam int NUM_LINES = 17;

line_entry_t lines_tbl [NUM_LINES] = '{
    '{  2,  3, 20,  3,  1, 19,  0, 1'b0},  // horizontal
    '{  5,  1,  5, 12,  2, 12,  0, 1'b0},  // vertical
    '{  0,  0, 15, 15,  3, 16,  0, 1'b0},  // 45 degrees, crosses the vertical
    '{ 10,  2, 14, 25,  4, 24,  0, 1'b0},  // steep
    '{  1, 20, 30, 26,  5, 30,  0, 1'b0},  // shallow
    '{ 28,  8,  6, 14,  6, 23,  0, 1'b0},  // right to left
    '{ 25, 30,  3, 18,  7, 23,  0, 1'b0},  // endpoints swapped
    '{ 17, 17, 17, 17,  8,  1,  0, 1'b0},  // single point
    '{ -6, 10,  5, 10,  9, 12,  6, 1'b0},  // off the left edge
    '{ 28, 28, 36, 36, 10,  9,  5, 1'b0},  // off the bottom right corner
    '{ 40, -5, 50, -2, 11, 11, 11, 1'b0},  // wholly off-screen
    '{ 20, -4, 20,  3, 12,  8,  4, 1'b0},  // crosses the top edge
    '{ 35,  9, 26,  0, 13, 10,  4, 1'b0},  // swapped and off the right edge
    '{  0, 31, 31, 31, 14, 32,  0, 1'b1},  // queued group, bottom row
    '{ 16, 20, 16, 31, 15, 12,  0, 1'b1},  // overwrites (16,31)
    '{  8, 23, 24, 23,  1, 17,  0, 1'b1},  // overwrites (16,23)
    '{ 12, 27, 20, 27,  2,  9,  0, 1'b1}   // overwrites (16,27)
};

string line_names [NUM_LINES] = '{
    "horizontal", "vertical", "diag45", "steep", "shallow", "right_to_left",
    "swapped", "single_point", "clip_left", "clip_corner", "offscreen",
    "clip_top", "clip_right_swapped", "queued_row", "queued_col",
    "queued_cross", "queued_short"
};

`endif

// File: bench/line_raster_tb.sv
// testbench top with clock, reset, credit-tracked line pushes, Bresenham model, readback, watchdog
`timescale 1ns/1ps

module line_raster_tb;
    import raster_pkg::*;

    `include "line_tb_table.svh"

    localparam int LINE_CYCLES    = FB_W + FB_H + 20;
    localparam int TIMEOUT_CYCLES = (NUM_LINES + FB_H) * LINE_CYCLES + 2 * FB_W * FB_H + 200;

    logic   clk = 1'b0;
    logic   rst;
    logic   cmd_valid;
    coord_t cmd_sx, cmd_sy, cmd_ex, cmd_ey;
    color_t cmd_color;
    logic   credit;
    logic   rd_en;
    coord_t rd_x, rd_y;
    color_t rd_data;
    logic   busy, line_done, pix_clipped;

    int          shadow [FB_H][FB_W];     // model image
    int          px_x[$];                 // visible pixels of the last modeled line
    int          px_y[$];
    logic [31:0] lfsr = 32'hc5d;
    int          pushes = 0;
    int          credit_pulses = 0;
    int          done_count = 0;
    int          xfer_count = 0;
    int          clip_count = 0;
    int          mismatches = 0;          // wrong values
    int          faults = 0;              // everything else

    line_raster_top dut_i (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid),
        .cmd_sx(cmd_sx), .cmd_sy(cmd_sy), .cmd_ex(cmd_ex), .cmd_ey(cmd_ey),
        .cmd_color(cmd_color), .credit(credit),
        .rd_en(rd_en), .rd_x(rd_x), .rd_y(rd_y), .rd_data(rd_data),
        .busy(busy), .line_done(line_done), .pix_clipped(pix_clipped)
    );

    always #5 clk = ~clk;

    // event counters sampled before the edge updates anything
    always @(posedge clk) begin
        if (!rst) begin
            if (credit)
                credit_pulses++;
            if (line_done)
                done_count++;
            if (dut_i.pix_bus.valid && dut_i.pix_bus.ready)
                xfer_count++;
            if (pix_clipped)
                clip_count++;
            assert (QUEUE_DEPTH + credit_pulses - pushes >= 0
                    && QUEUE_DEPTH + credit_pulses - pushes <= QUEUE_DEPTH) else begin
                $display("host credit count left its range: %0d held",
                         QUEUE_DEPTH + credit_pulses - pushes);
                faults++;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic model_line(input int sx, input int sy, input int ex, input int ey,
                              input int color, output int npix, output int nclip);
        int  x0, y0, x1, y1, dx, dy, err, e2, step;
        bit  finished;
        if (sy > ey) begin                // walk with y increasing
            x0 = ex;
            y0 = ey;
            x1 = sx;
            y1 = sy;
        end else begin
            x0 = sx;
            y0 = sy;
            x1 = ex;
            y1 = ey;
        end
        dx = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy = y0 - y1;                     // negative y span
        step = (x0 < x1) ? 1 : -1;
        err = dx + dy;
        npix = 0;
        nclip = 0;
        finished = 1'b0;
        px_x.delete();
        px_y.delete();
        while (!finished) begin
            npix++;
            if (x0 >= 0 && x0 < FB_W && y0 >= 0 && y0 < FB_H) begin
                shadow[y0][x0] = color;
                px_x.push_back(x0);
                px_y.push_back(y0);
            end else begin
                nclip++;
            end
            if (x0 == x1 && y0 == y1) begin
                finished = 1'b1;
            end else begin
                e2 = 2 * err;
                if (e2 >= dy) begin
                    err += dy;
                    x0 += step;
                end
                if (e2 <= dx) begin
                    err += dx;
                    y0++;
                end
            end
        end
    endtask

    // waits for a credit and then offers the command for one cycle
    task automatic push_line(input int sx, input int sy, input int ex, input int ey,
                             input int color);
        while (QUEUE_DEPTH + credit_pulses - pushes <= 0) @(negedge clk);
        cmd_sx    = coord_t'(sx);
        cmd_sy    = coord_t'(sy);
        cmd_ex    = coord_t'(ex);
        cmd_ey    = coord_t'(ey);
        cmd_color = color_t'(color);
        cmd_valid = 1'b1;
        pushes++;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    // random host reads while drawing stall the pixel stream
    task automatic wait_done(input int target);
        int r;
        while (done_count < target) begin
            take_bits(2, r);
            if (r == 3 && busy) begin
                rd_en = 1'b1;
                take_bits(5, r);
                rd_x = coord_t'(r);
                take_bits(5, r);
                rd_y = coord_t'(r);
            end else begin
                rd_en = 1'b0;
            end
            @(negedge clk);
        end
        rd_en = 1'b0;
    endtask

    task automatic read_px(input int x, input int y, output color_t v);
        rd_en = 1'b1;
        rd_x  = coord_t'(x);
        rd_y  = coord_t'(y);
        @(negedge clk);
        rd_en = 1'b0;
        v = rd_data;                      // registered on the edge just past
    endtask

    task automatic check_count(input string name, input string what,
                               input int expected, input int actual);
        assert (expected == actual) else begin
            $display("FAIL %s %s: expected %0d, actual %0d", name, what, expected, actual);
            mismatches++;
        end
    endtask

    // models, draws, counts and reads back one line on its own
    task automatic run_line(input string name, input int sx, input int sy, input int ex,
                            input int ey, input int color, input int exp_pix,
                            input int exp_clip);
        int     npix, nclip, xfer0, clip0, done0;
        color_t v;
        model_line(sx, sy, ex, ey, color, npix, nclip);
        check_count(name, "model pixels", exp_pix, npix);
        check_count(name, "model clips", exp_clip, nclip);
        xfer0 = xfer_count;
        clip0 = clip_count;
        done0 = done_count;
        push_line(sx, sy, ex, ey, color);
        wait_done(done0 + 1);
        check_count(name, "pixels", exp_pix, xfer_count - xfer0);
        check_count(name, "clips", exp_clip, clip_count - clip0);
        for (int i = 0; i < px_x.size(); i++) begin
            read_px(px_x[i], px_y[i], v);
            assert (v == color_t'(color)) else begin
                $display("FAIL %s (%0d,%0d): expected %0h, actual %0h",
                         name, px_x[i], px_y[i], color, v);
                mismatches++;
            end
        end
        check_count(name, "line_done pulses", 1, done_count - done0);
    endtask

    initial begin
        int     gpix, gclip, npix, nclip, xfer0, clip0, done0, nq;
        color_t v;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_sx = '0;
        cmd_sy = '0;
        cmd_ex = '0;
        cmd_ey = '0;
        cmd_color = '0;
        rd_en = 1'b0;
        rd_x = '0;
        rd_y = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!credit && !busy && !line_done && !pix_clipped) else begin
            $display("status outputs not low after reset");
            faults++;
        end

        for (int y = 0; y < FB_H; y++) begin
            run_line("clear", 0, y, FB_W - 1, y, 0, FB_W, 0);     // blank the frame
        end

        for (int i = 0; i < NUM_LINES; i++) begin
            if (!lines_tbl[i].queued) begin
                run_line(line_names[i], lines_tbl[i].sx, lines_tbl[i].sy, lines_tbl[i].ex,
                         lines_tbl[i].ey, lines_tbl[i].color, lines_tbl[i].exp_pix,
                         lines_tbl[i].exp_clip);
            end
        end

        // queued rows go in back to back with the model applied in the same order
        gpix = 0;
        gclip = 0;
        nq = 0;
        xfer0 = xfer_count;
        clip0 = clip_count;
        done0 = done_count;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (lines_tbl[i].queued) begin
                model_line(lines_tbl[i].sx, lines_tbl[i].sy, lines_tbl[i].ex, lines_tbl[i].ey,
                           lines_tbl[i].color, npix, nclip);
                check_count(line_names[i], "model pixels", lines_tbl[i].exp_pix, npix);
                check_count(line_names[i], "model clips", lines_tbl[i].exp_clip, nclip);
                gpix += lines_tbl[i].exp_pix;
                gclip += lines_tbl[i].exp_clip;
                nq++;
                push_line(lines_tbl[i].sx, lines_tbl[i].sy, lines_tbl[i].ex, lines_tbl[i].ey,
                          lines_tbl[i].color);
            end
        end
        wait_done(done0 + nq);
        check_count("queued", "pixels", gpix, xfer_count - xfer0);
        check_count("queued", "clips", gclip, clip_count - clip0);

        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                read_px(x, y, v);
                assert (v == color_t'(shadow[y][x])) else begin
                    $display("FAIL final_image (%0d,%0d): expected %0h, actual %0h",
                             x, y, shadow[y][x], v);
                    mismatches++;
                end
            end
        end

        check_count("credits", "pulses", pushes, credit_pulses);
        check_count("credits", "held at end", QUEUE_DEPTH, QUEUE_DEPTH + credit_pulses - pushes);
        check_count("queued", "line_done pulses", nq, done_count - done0);
        assert (!busy) else begin
            $display("drawer still busy after the last line");
            faults++;
        end

        $display("summary: %0d value mismatches, %0d other errors", mismatches, faults);
        if (mismatches == 0 && faults == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+bench
rtl/raster_pkg.sv
rtl/pix_if.sv
rtl/cmd_queue.sv
rtl/line_drawer.sv
rtl/frame_store.sv
rtl/line_raster_top.sv
bench/line_raster_tb.sv

// File: run.sh
#!/bin/sh
# build and run the line rasterizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module line_raster_tb \
    -Mdir obj_dir -o line_raster_sim

if ! ./obj_dir/line_raster_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    exit 1
fi
exit 0
